/* source/cpu_pkg.sv */
package cpu_pkg;

  typedef logic [15:0] word_t;
  typedef logic [3:0] reg_idx_t;

  // Opcode 4 is the canonical no-op, other unlisted codes behave the same
  typedef enum logic [3:0] {
    op_add  = 4'h0,
    op_sub  = 4'h1,
    op_xor  = 4'h2,
    op_addi = 4'h3,
    op_nop  = 4'h4,
    op_lw   = 4'h8,
    op_sw   = 4'h9,
    op_llb  = 4'ha,
    op_b    = 4'hc,
    op_hlt  = 4'hf
  } opcode_e;

  typedef enum logic [2:0] {
    cond_ne     = 3'b000,
    cond_eq     = 3'b001,
    cond_lt     = 3'b010,
    cond_always = 3'b111
  } cond_e;

  typedef struct packed {
    logic z;
    logic v;
    logic n;
  } flags_t;

  typedef struct packed {
    logic reg_write;
    logic mem_read;
    logic mem_write;
    logic alu_src;
    logic load_byte;
    logic halt;
  } ctrl_t;

  typedef enum logic [1:0] {
    fwd_none     = 2'd0,
    fwd_from_mem = 2'd1,
    fwd_from_wb  = 2'd2
  } fwd_sel_e;

  typedef struct packed {
    ctrl_t    ctrl;
    opcode_e  opcode;
    reg_idx_t rd;
    reg_idx_t rs;
    reg_idx_t rt;
    word_t    op_a;
    word_t    op_b;
    logic [7:0] imm8;
  } id_ex_t;

  typedef struct packed {
    ctrl_t    ctrl;
    reg_idx_t rd;
    word_t    alu_out;
    word_t    store_data;
  } ex_mem_t;

  typedef struct packed {
    ctrl_t    ctrl;
    reg_idx_t rd;
    word_t    alu_out;
    word_t    mem_data;
  } mem_wb_t;

  typedef struct packed {
    word_t addr;
    word_t wdata;
    logic  we;
    logic  re;
  } dmem_req_t;

  localparam word_t pc_step = 16'd2;
  localparam int reg_count = 16;
  // Encoding fed into decode for squashed slots and after reset
  localparam word_t nop_instr = 16'h4000;

endpackage

/* source/stage_reg.sv */
`timescale 1ns/1ps

module stage_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     hold,
  input  logic     bubble,
  input  payload_t d,
  output payload_t q
);

  // An all-zero payload carries an inactive control word
  always_ff @(posedge clk) begin
    if (rst) begin
      q <= '0;
    end else if (!hold) begin
      if (bubble) begin
        q <= '0;
      end else begin
        q <= d;
      end
    end
  end

endmodule

/* source/register_file.sv */
`timescale 1ns/1ps

module register_file (
  input  logic             clk,
  input  logic             rst,
  input  cpu_pkg::reg_idx_t rs_idx,
  input  cpu_pkg::reg_idx_t rt_idx,
  input  logic             wr_en,
  input  cpu_pkg::reg_idx_t wr_idx,
  input  cpu_pkg::word_t    wr_data,
  output cpu_pkg::word_t    rs_data,
  output cpu_pkg::word_t    rt_data
);
  import cpu_pkg::*;

  word_t regs [reg_count];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < reg_count; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && wr_idx != '0) begin
      regs[wr_idx] <= wr_data;
    end
  end

  // Bypass the write port so decode sees write-back in the same cycle
  assign rs_data = (rs_idx == '0) ? '0 : (wr_en && wr_idx == rs_idx) ? wr_data : regs[rs_idx];
  assign rt_data = (rt_idx == '0) ? '0 : (wr_en && wr_idx == rt_idx) ? wr_data : regs[rt_idx];

endmodule

/* source/decoder.sv */
`timescale 1ns/1ps

module decoder (
  input  cpu_pkg::word_t    instr,
  output cpu_pkg::ctrl_t    ctrl,
  output cpu_pkg::opcode_e  opcode,
  output cpu_pkg::reg_idx_t rd,
  output cpu_pkg::reg_idx_t rs_idx,
  output cpu_pkg::reg_idx_t rt_idx,
  output logic              is_branch,
  output cpu_pkg::cond_e    cond
);
  import cpu_pkg::*;

  assign opcode = opcode_e'(instr[15:12]);
  assign rd     = instr[11:8];
  assign cond   = cond_e'(instr[11:9]);

  // LLB keeps the upper byte of rd, SW stores rd
  assign rs_idx = (opcode == op_llb) ? instr[11:8] : instr[7:4];
  assign rt_idx = (opcode == op_sw) ? instr[11:8] : instr[3:0];

  assign is_branch = (opcode == op_b);

  always_comb begin
    ctrl = '0;
    case (opcode)
      op_add, op_sub, op_xor: begin
        ctrl.reg_write = 1'b1;
      end
      op_addi: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src   = 1'b1;
      end
      op_lw: begin
        ctrl.reg_write = 1'b1;
        ctrl.mem_read  = 1'b1;
        ctrl.alu_src   = 1'b1;
      end
      // rt holds a register here, so alu_src stays clear
      op_sw: begin
        ctrl.mem_write = 1'b1;
      end
      op_llb: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src   = 1'b1;
        ctrl.load_byte = 1'b1;
      end
      op_hlt: begin
        ctrl.halt = 1'b1;
      end
      default: begin
        ctrl = '0;
      end
    endcase
  end

endmodule

/* source/branch_unit.sv */
`timescale 1ns/1ps

module branch_unit (
  input  logic            is_branch,
  input  cpu_pkg::cond_e  cond,
  input  cpu_pkg::word_t  instr,
  input  cpu_pkg::word_t  pc_next,
  input  cpu_pkg::flags_t flags,
  output logic            taken,
  output cpu_pkg::word_t  target
);
  import cpu_pkg::*;

  logic cond_met;

  always_comb begin
    case (cond)
      cond_ne:     cond_met = ~flags.z;
      cond_eq:     cond_met = flags.z;
      cond_lt:     cond_met = flags.n;
      cond_always: cond_met = 1'b1;
      default:     cond_met = 1'b0;
    endcase
  end

  assign taken = is_branch & cond_met;

  // Offset counts words, so shift by one before adding
  assign target = pc_next + {{6{instr[8]}}, instr[8:0], 1'b0};

endmodule

/* source/alu.sv */
`timescale 1ns/1ps

module alu (
  input  logic             clk,
  input  logic             rst,
  input  cpu_pkg::opcode_e opcode,
  input  logic             load_byte,
  input  logic             alu_src,
  input  cpu_pkg::word_t   a,
  input  cpu_pkg::word_t   b,
  input  cpu_pkg::word_t   imm,
  output cpu_pkg::word_t   result,
  output cpu_pkg::flags_t  flags
);
  import cpu_pkg::*;

  word_t  b_eff;
  word_t  sum;
  word_t  diff;
  flags_t flags_d;
  logic   set_flags;

  // Memory ops share the adder with ADDI
  assign b_eff = (alu_src || opcode == op_sw) ? imm : b;
  assign sum   = a + b_eff;
  assign diff  = a - b;

  always_comb begin
    case (opcode)
      op_sub:  result = diff;
      op_xor:  result = a ^ b;
      default: result = sum;
    endcase
    if (load_byte) begin
      result = {a[15:8], imm[7:0]};
    end
  end

  always_comb begin
    flags_d.z = (result == '0);
    flags_d.n = result[15];
    case (opcode)
      op_sub:  flags_d.v = (a[15] != b[15]) && (diff[15] != a[15]);
      op_xor:  flags_d.v = 1'b0;
      default: flags_d.v = (a[15] == b_eff[15]) && (sum[15] != a[15]);
    endcase
  end

  assign set_flags = opcode inside {op_add, op_sub, op_xor, op_addi};

  always_ff @(posedge clk) begin
    if (rst) begin
      flags <= '0;
    end else if (set_flags) begin
      flags <= flags_d;
    end
  end

endmodule

/* source/hazard_unit.sv */
`timescale 1ns/1ps

module hazard_unit (
  input  cpu_pkg::reg_idx_t id_rs,
  input  cpu_pkg::reg_idx_t id_rt,
  input  logic              id_uses_rt,
  input  cpu_pkg::id_ex_t   ex_stage,
  input  cpu_pkg::ex_mem_t  mem_stage,
  input  cpu_pkg::mem_wb_t  wb_stage,
  output cpu_pkg::fwd_sel_e fwd_a,
  output cpu_pkg::fwd_sel_e fwd_b,
  output logic              fwd_store,
  output logic              load_stall
);
  import cpu_pkg::*;

  logic mem_writes;
  logic wb_writes;

  assign mem_writes = mem_stage.ctrl.reg_write && mem_stage.rd != '0;
  assign wb_writes  = wb_stage.ctrl.reg_write && wb_stage.rd != '0;

  // Newer result in memory wins over write-back
  always_comb begin
    fwd_a = fwd_none;
    if (mem_writes && mem_stage.rd == ex_stage.rs) begin
      fwd_a = fwd_from_mem;
    end else if (wb_writes && wb_stage.rd == ex_stage.rs) begin
      fwd_a = fwd_from_wb;
    end

    fwd_b = fwd_none;
    if (!ex_stage.ctrl.alu_src) begin
      if (mem_writes && mem_stage.rd == ex_stage.rt) begin
        fwd_b = fwd_from_mem;
      end else if (wb_writes && wb_stage.rd == ex_stage.rt) begin
        fwd_b = fwd_from_wb;
      end
    end
  end

  // Store right behind a load of its data register
  assign fwd_store = mem_stage.ctrl.mem_write && wb_stage.ctrl.mem_read && wb_writes &&
                     wb_stage.rd == mem_stage.rd;

  assign load_stall = ex_stage.ctrl.mem_read && ex_stage.rd != '0 &&
                      (ex_stage.rd == id_rs || (id_uses_rt && ex_stage.rd == id_rt));

endmodule

/* source/cpu.sv */
`timescale 1ns/1ps

module cpu (
  input  logic               clk,
  input  logic               rst,
  output cpu_pkg::word_t     imem_addr,
  input  cpu_pkg::word_t     imem_data,
  output cpu_pkg::dmem_req_t dmem_req,
  input  cpu_pkg::word_t     dmem_rdata,
  output cpu_pkg::word_t     pc,
  output logic               hlt
);
  import cpu_pkg::*;

  word_t    ir;
  word_t    id_pc_next;
  ctrl_t    dec_ctrl;
  opcode_e  dec_opcode;
  reg_idx_t dec_rd;
  reg_idx_t dec_rs;
  reg_idx_t dec_rt;
  logic     dec_is_branch;
  cond_e    dec_cond;
  word_t    rs_data;
  word_t    rt_data;
  logic     br_taken;
  word_t    br_target;
  flags_t   flags;
  logic     id_hold;
  id_ex_t   id_ex_d;
  id_ex_t   ex;
  ex_mem_t  ex_mem_d;
  ex_mem_t  mem;
  mem_wb_t  mem_wb_d;
  mem_wb_t  wb;
  fwd_sel_e fwd_a;
  fwd_sel_e fwd_b;
  logic     fwd_store;
  logic     load_stall;
  word_t    a_val;
  word_t    b_val;
  word_t    ex_imm;
  opcode_e  alu_opcode;
  word_t    alu_result;
  word_t    store_wdata;
  word_t    wb_result;

  // Fetch holds on a load-use stall and once HLT sits in decode
  assign id_hold   = load_stall | dec_ctrl.halt;
  assign imem_addr = pc;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
      ir <= nop_instr;
    end else if (!id_hold) begin
      pc <= br_taken ? br_target : pc + pc_step;
      ir <= br_taken ? nop_instr : imem_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!id_hold) begin
      id_pc_next <= pc + pc_step;
    end
  end

  decoder i_decoder (
    .instr(ir), .ctrl(dec_ctrl), .opcode(dec_opcode), .rd(dec_rd), .rs_idx(dec_rs),
    .rt_idx(dec_rt), .is_branch(dec_is_branch), .cond(dec_cond)
  );

  register_file i_register_file (
    .clk(clk), .rst(rst), .rs_idx(dec_rs), .rt_idx(dec_rt), .wr_en(wb.ctrl.reg_write),
    .wr_idx(wb.rd), .wr_data(wb_result), .rs_data(rs_data), .rt_data(rt_data)
  );

  branch_unit i_branch_unit (
    .is_branch(dec_is_branch), .cond(dec_cond), .instr(ir), .pc_next(id_pc_next),
    .flags(flags), .taken(br_taken), .target(br_target)
  );

  hazard_unit i_hazard_unit (
    .id_rs(dec_rs), .id_rt(dec_rt), .id_uses_rt(dec_ctrl.reg_write & ~dec_ctrl.alu_src),
    .ex_stage(ex), .mem_stage(mem), .wb_stage(wb), .fwd_a(fwd_a), .fwd_b(fwd_b),
    .fwd_store(fwd_store), .load_stall(load_stall)
  );

  assign id_ex_d = '{ctrl: dec_ctrl, opcode: dec_opcode, rd: dec_rd, rs: dec_rs, rt: dec_rt,
                     op_a: rs_data, op_b: rt_data, imm8: ir[7:0]};

  stage_reg #(.payload_t(id_ex_t)) i_id_ex (
    .clk(clk), .rst(rst), .hold(hlt), .bubble(load_stall), .d(id_ex_d), .q(ex)
  );

  always_comb begin
    case (fwd_a)
      fwd_from_mem: a_val = mem.alu_out;
      fwd_from_wb:  a_val = wb_result;
      default:      a_val = ex.op_a;
    endcase
    case (fwd_b)
      fwd_from_mem: b_val = mem.alu_out;
      fwd_from_wb:  b_val = wb_result;
      default:      b_val = ex.op_b;
    endcase
  end

  // LLB wants the raw byte, everything else a sign-extended nibble
  assign ex_imm = ex.ctrl.load_byte ? {8'h00, ex.imm8} : {{12{ex.imm8[3]}}, ex.imm8[3:0]};

  // A bubble decodes as ADD, so keep it away from the flags
  assign alu_opcode = (|ex.ctrl) ? ex.opcode : op_nop;

  alu i_alu (
    .clk(clk), .rst(rst), .opcode(alu_opcode), .load_byte(ex.ctrl.load_byte),
    .alu_src(ex.ctrl.alu_src), .a(a_val), .b(b_val), .imm(ex_imm), .result(alu_result),
    .flags(flags)
  );

  assign ex_mem_d = '{ctrl: ex.ctrl, rd: ex.rd, alu_out: alu_result, store_data: b_val};

  stage_reg #(.payload_t(ex_mem_t)) i_ex_mem (
    .clk(clk), .rst(rst), .hold(hlt), .bubble(1'b0), .d(ex_mem_d), .q(mem)
  );

  assign store_wdata = fwd_store ? wb.mem_data : mem.store_data;
  assign dmem_req    = '{addr: mem.alu_out, wdata: store_wdata, we: mem.ctrl.mem_write,
                         re: mem.ctrl.mem_read};
  assign mem_wb_d    = '{ctrl: mem.ctrl, rd: mem.rd, alu_out: mem.alu_out, mem_data: dmem_rdata};

  stage_reg #(.payload_t(mem_wb_t)) i_mem_wb (
    .clk(clk), .rst(rst), .hold(hlt), .bubble(1'b0), .d(mem_wb_d), .q(wb)
  );

  assign wb_result = wb.ctrl.mem_read ? wb.mem_data : wb.alu_out;

  // Sticky until reset
  always_ff @(posedge clk) begin
    if (rst) begin
      hlt <= 1'b0;
    end else if (wb.ctrl.halt) begin
      hlt <= 1'b1;
    end
  end

endmodule

/* bench/tb_cpu.sv */
`timescale 1ns/1ps

module tb_cpu;
  import cpu_pkg::*;

  localparam int reset_cycles = 5;
  localparam int model_steps  = 1000;

  logic      clk;
  logic      rst;
  word_t     imem_addr;
  word_t     imem_data;
  dmem_req_t dmem_req;
  word_t     dmem_rdata;
  word_t     pc;
  logic      hlt;

  word_t imem [256];
  word_t dmem [256];
  word_t mdl_mem [256];
  word_t got_addr [$];
  word_t got_data [$];
  word_t exp_addr [$];
  word_t exp_data [$];

  int          prog_len;
  int          errors;
  int          checks;
  int          cycle_count;
  int          cycle_limit;
  logic [31:0] lfsr = 32'hec1e;

  cpu i_cpu (
    .clk(clk), .rst(rst), .imem_addr(imem_addr), .imem_data(imem_data),
    .dmem_req(dmem_req), .dmem_rdata(dmem_rdata), .pc(pc), .hlt(hlt)
  );

  // Both memories are word arrays read without latency
  assign imem_data  = imem[imem_addr[8:1]];
  // Read data is only valid while the load strobe is up
  assign dmem_rdata = dmem_req.re ? dmem[dmem_req.addr[8:1]] : 'x;

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    if (dmem_req.we === 1'b1) begin
      dmem[dmem_req.addr[8:1]] <= dmem_req.wdata;
      got_addr.push_back(dmem_req.addr);
      got_data.push_back(dmem_req.wdata);
    end
  end

  // Limit grows as each test adds its own budget
  initial begin
    cycle_count = 0;
    while (cycle_count <= cycle_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: hlt did not rise within %0d cycles", cycle_limit);
    $display("Test FAILED");
    $finish;
  end

  task automatic expect_equal(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t %s: got %h, expected %h", $time, name, got, exp);
    end
  endtask

  function automatic logic [31:0] galois_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [15:0] random_bits(input int count);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < count; i++) begin
      lfsr = galois_step(lfsr);
      v = {v[14:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic word_t encode(input logic [3:0] op, input logic [3:0] a,
                                   input logic [3:0] b, input logic [3:0] c);
    return {op, a, b, c};
  endfunction

  function automatic word_t llb_instr(input logic [3:0] rd, input logic [7:0] imm8);
    return {4'ha, rd, imm8};
  endfunction

  function automatic word_t branch_instr(input logic [2:0] cond, input logic [8:0] offset);
    return {4'hc, cond, offset};
  endfunction

  task automatic emit(input word_t instr);
    imem[prog_len] = instr;
    prog_len++;
  endtask

  // Unused words decode as HLT, whatever their low bits
  task automatic clear_program();
    for (int i = 0; i < 256; i++) begin
      imem[i] = {8'hf0, 8'(i)};
    end
    prog_len = 0;
  endtask

  task automatic fill_data();
    for (int i = 0; i < 256; i++) begin
      dmem[i] = {8'(i) ^ 8'h5a, ~8'(i)};
    end
  endtask

  // Sequential ISA model, one instruction at a time
  task automatic run_model(output int executed);
    word_t regs [16];
    word_t mpc;
    word_t ins;
    word_t a;
    word_t b;
    word_t imm;
    word_t res;
    logic  z;
    logic  n;
    logic  wr;
    logic  setf;
    logic  taken;
    logic  done;
    for (int i = 0; i < 16; i++) begin
      regs[i] = '0;
    end
    for (int i = 0; i < 256; i++) begin
      mdl_mem[i] = dmem[i];
    end
    exp_addr.delete();
    exp_data.delete();
    mpc = '0;
    z = 1'b0;
    n = 1'b0;
    done = 1'b0;
    executed = 0;
    while (!done && executed < model_steps) begin
      ins = imem[mpc[8:1]];
      executed++;
      a = regs[ins[7:4]];
      b = regs[ins[3:0]];
      imm = {{12{ins[3]}}, ins[3:0]};
      mpc = mpc + 16'd2;
      res = '0;
      wr = 1'b0;
      setf = 1'b0;
      case (ins[15:12])
        op_add: {res, wr, setf} = {a + b, 2'b11};
        op_sub: {res, wr, setf} = {a - b, 2'b11};
        op_xor: {res, wr, setf} = {a ^ b, 2'b11};
        op_addi: {res, wr, setf} = {a + imm, 2'b11};
        op_lw: {res, wr} = {mdl_mem[8'((a + imm) >> 1)], 1'b1};
        op_sw: begin
          mdl_mem[8'((a + imm) >> 1)] = regs[ins[11:8]];
          exp_addr.push_back(a + imm);
          exp_data.push_back(regs[ins[11:8]]);
        end
        op_llb: {res, wr} = {regs[ins[11:8]][15:8], ins[7:0], 1'b1};
        op_b: begin
          case (ins[11:9])
            3'b000: taken = !z;
            3'b001: taken = z;
            3'b010: taken = n;
            3'b111: taken = 1'b1;
            default: taken = 1'b0;
          endcase
          if (taken) begin
            mpc = mpc + {{6{ins[8]}}, ins[8:0], 1'b0};
          end
        end
        op_hlt: done = 1'b1;
        default: ;
      endcase
      if (setf) begin
        z = (res == '0);
        n = res[15];
      end
      if (wr && ins[11:8] != 4'd0) begin
        regs[ins[11:8]] = res;
      end
    end
    if (!done) begin
      errors++;
      $display("Reference model ran %0d instructions without reaching HLT", executed);
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    rst <= 1'b1;
    repeat (reset_cycles) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    expect_equal("pc", pc, 16'h0000);
    expect_equal("hlt", hlt, 1'b0);
    expect_equal("dmem_req.we", dmem_req.we, 1'b0);
    expect_equal("dmem_req.re", dmem_req.re, 1'b0);
    got_addr.delete();
    got_data.delete();
  endtask

  task automatic run_program();
    int executed;
    run_model(executed);
    cycle_limit += 4 * executed + 20 + reset_cycles + 1;
    apply_reset();
    while (hlt !== 1'b1) begin
      @(negedge clk);
    end
    expect_equal("store count", got_addr.size(), exp_addr.size());
    for (int i = 0; i < got_addr.size() && i < exp_addr.size(); i++) begin
      expect_equal($sformatf("store[%0d] addr", i), got_addr[i], exp_addr[i]);
      expect_equal($sformatf("store[%0d] data", i), got_data[i], exp_data[i]);
    end
    for (int i = 0; i < 256; i++) begin
      expect_equal($sformatf("dmem[%0d]", i), dmem[i], mdl_mem[i]);
    end
  endtask

  task automatic reset_test();
    clear_program();
    fill_data();
    emit(encode(op_nop, 0, 0, 0));
    emit(encode(op_nop, 0, 0, 0));
    emit(llb_instr(9, 8'h10));
    emit(llb_instr(2, 8'ha5));
    emit(encode(op_sw, 2, 9, 0));
    emit(encode(op_hlt, 0, 0, 0));
    run_program();
  endtask

  task automatic forwarding_test();
    logic [7:0] b0;
    logic [7:0] b1;
    logic [3:0] k0;
    logic [3:0] k1;
    for (int round = 0; round < 2; round++) begin
      b0 = 8'(random_bits(8));
      b1 = 8'(random_bits(8));
      k0 = 4'(random_bits(4));
      k1 = 4'(random_bits(4));
      clear_program();
      fill_data();
      emit(llb_instr(9, 8'h40));
      emit(llb_instr(1, b0));
      emit(llb_instr(2, b1));
      emit(encode(op_add, 3, 1, 1));
      emit(encode(op_add, 3, 3, 3));
      emit(encode(op_add, 3, 3, 3));
      emit(encode(op_add, 3, 3, 3));
      emit(encode(op_add, 4, 3, 2));
      emit(encode(op_sw, 4, 9, 0));
      emit(encode(op_sub, 5, 2, 4));
      emit(encode(op_xor, 6, 5, 3));
      emit(encode(op_sw, 5, 9, 2));
      emit(encode(op_sw, 6, 9, 4));
      emit(encode(op_addi, 7, 6, k0));
      emit(encode(op_add, 8, 7, 5));
      emit(encode(op_sw, 8, 9, 6));
      emit(encode(op_sub, 10, 8, 7));
      emit(encode(op_addi, 10, 10, k1));
      emit(encode(op_sw, 10, 9, 4'he));
      emit(encode(op_sw, 7, 9, 4'hc));
      // Write to r0 must be dropped
      emit(encode(op_xor, 0, 8, 7));
      emit(encode(op_add, 11, 0, 10));
      emit(encode(op_sw, 11, 9, 4'ha));
      emit(encode(op_hlt, 0, 0, 0));
      run_program();
    end
  endtask

  task automatic load_use_test();
    clear_program();
    fill_data();
    emit(llb_instr(9, 8'h20));
    emit(encode(op_lw, 1, 9, 0));
    emit(encode(op_add, 2, 1, 1));
    emit(encode(op_lw, 3, 9, 2));
    emit(encode(op_add, 4, 2, 3));
    emit(encode(op_lw, 5, 9, 4));
    emit(encode(op_sw, 5, 9, 6));
    emit(encode(op_lw, 6, 9, 4'he));
    emit(encode(op_sw, 6, 9, 4'hc));
    emit(encode(op_lw, 7, 9, 6));
    emit(encode(op_addi, 8, 7, 1));
    emit(encode(op_sw, 2, 9, 0));
    emit(encode(op_sw, 4, 9, 2));
    emit(encode(op_sw, 8, 9, 4));
    emit(encode(op_hlt, 0, 0, 0));
    run_program();
  endtask

  // Marker bump, flag setter, filler store, branch over two stores
  task automatic branch_block(input logic [2:0] cond, input word_t setter);
    emit(encode(op_addi, 11, 11, 1));
    emit(setter);
    emit(encode(op_sw, 11, 9, 0));
    emit(branch_instr(cond, 9'd2));
    emit(encode(op_sw, 11, 9, 2));
    emit(encode(op_sw, 11, 9, 4));
  endtask

  task automatic branch_test();
    word_t zero_set;
    word_t positive;
    word_t negative;
    zero_set = encode(op_xor, 1, 2, 2);
    positive = encode(op_addi, 1, 0, 5);
    negative = encode(op_addi, 1, 0, 4'hd);
    clear_program();
    fill_data();
    emit(llb_instr(9, 8'h80));
    branch_block(3'b000, positive);
    branch_block(3'b000, zero_set);
    branch_block(3'b001, zero_set);
    branch_block(3'b001, positive);
    branch_block(3'b010, negative);
    branch_block(3'b010, positive);
    branch_block(3'b111, zero_set);
    branch_block(3'b011, negative);
    emit(encode(op_hlt, 0, 0, 0));
    run_program();
  endtask

  task automatic halt_test();
    int    hlt_index;
    int    stores_seen;
    clear_program();
    fill_data();
    emit(llb_instr(9, 8'h60));
    emit(llb_instr(1, 8'h77));
    emit(encode(op_sw, 1, 9, 0));
    emit(encode(op_addi, 1, 1, 1));
    emit(encode(op_sw, 1, 9, 2));
    hlt_index = prog_len;
    emit(encode(op_hlt, 0, 0, 0));
    emit(encode(op_sw, 1, 9, 4));
    emit(encode(op_addi, 1, 1, 1));
    emit(encode(op_sw, 1, 9, 6));
    run_program();
    stores_seen = got_addr.size();
    repeat (20) begin
      @(negedge clk);
      expect_equal("pc", pc, 16'(2 * hlt_index + 2));
      expect_equal("hlt", hlt, 1'b1);
    end
    expect_equal("store count after halt", got_addr.size(), stores_seen);
  endtask

  initial begin
    rst = 1'b1;
    errors = 0;
    checks = 0;
    cycle_limit = 0;
    clear_program();
    fill_data();
    reset_test();
    forwarding_test();
    load_use_test();
    branch_test();
    halt_test();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* cpu_pipe.f */
source/cpu_pkg.sv
source/stage_reg.sv
source/register_file.sv
source/decoder.sv
source/branch_unit.sv
source/alu.sv
source/hazard_unit.sv
source/cpu.sv
bench/tb_cpu.sv
